// ==== verilog/wordAligner_settings.svh ====
// Aligner constants; WA_BUFFER_WORDS must stay 4 and WA_COMMA_DELAY must be at least 2
`ifndef WORD_ALIGNER_SETTINGS_SVH
`define WORD_ALIGNER_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Comma search
////////////////////////////////////////////////////////////////////////////

// Consecutive commas needed before an offset is accepted
// Run counters are 4 bits wide so keep this below 16
`define WA_COMMAS_TO_DETECT 3

// K28 comma searched for (1, 5 or 7)
`define WA_COMMA_SELECT 5

////////////////////////////////////////////////////////////////////////////
// Synchronization
////////////////////////////////////////////////////////////////////////////

// Stages in the comma-found delay line
`define WA_COMMA_DELAY 4

// Consecutive code errors that drop synchronization
`define WA_ERROR_TRIGGER 4

// Word shift buffer depth, tied to the offset rule
`define WA_BUFFER_WORDS 4

`endif

// ==== verilog/lineCodePkg.sv ====
// 8b/10b line code definitions; bit 9 of a code group is the first bit on the line
`default_nettype none

package lineCodePkg;

  // One 10-bit code group as received
  typedef logic [9:0] codeGroup_t;

  // K28.1 comma
  // Pos is the group sent at positive running disparity
  localparam codeGroup_t k28Dot1Pos = 10'b1100000110;
  localparam codeGroup_t k28Dot1Neg = 10'b0011111001;

  // K28.5 comma
  // The usual idle and alignment character
  localparam codeGroup_t k28Dot5Pos = 10'b1100000101;
  localparam codeGroup_t k28Dot5Neg = 10'b0011111010;

  // K28.7 comma
  // Repeated K28.7 can alias at other offsets
  localparam codeGroup_t k28Dot7Pos = 10'b1100000111;
  localparam codeGroup_t k28Dot7Neg = 10'b0011111000;

  // All three share the comma prefix 0011111 or 1100000
  // Bits 9 down to 3 carry it
  // Only these three K codes contain a singular comma

endpackage

`default_nettype wire

// ==== verilog/alignerPkg.sv ====
// Aligner internal types; offsets run 0 to 9 and all counters are 4 bits wide
`default_nettype none

package alignerPkg;

  // Bit offset inside the 20-bit word pair
  typedef logic [3:0] wordOffset_t;

  // One found flag per offset
  typedef logic [9:0] offsetMask_t;

  // Consecutive comma run length
  typedef logic [3:0] runCount_t;

  // Offset selection FSM
  // Idle waits for a search request
  // Select waits for exactly one found offset
  // Lock holds the offset until the monitor confirms sync
  // Settle is one cycle before returning to Idle
  typedef enum logic [1:0] {
    Idle   = 2'b00,
    Select = 2'b01,
    Lock   = 2'b10,
    Settle = 2'b11
  } alignState_t;

  // Search/sync FSM of the monitor
  typedef enum logic {
    Search = 1'b0,
    Sync   = 1'b1
  } syncState_t;

  // Consecutive code error count
  typedef logic [3:0] errorCount_t;

endpackage

`default_nettype wire

// ==== verilog/codeGroupBuffer.sv ====
// Four-word buffer and offset tap; output lags the completing word by 3 cycles and is 0 without an offset
`timescale 1ns/10ps
`default_nettype none

`include "wordAligner_settings.svh"

module codeGroupBuffer
  import lineCodePkg::*, alignerPkg::*;
(
  input  wire         CLK,
  input  wire         aresetn,
  input  codeGroup_t  dataIn,
  input  wordOffset_t offset,
  input  logic        offsetValid,
  output logic [19:0] window,
  output codeGroup_t  alignedData
);

  // Word 0 is the newest
  codeGroup_t wordBuf [`WA_BUFFER_WORDS];

  // Oldest pair feeds the output tap
  logic [19:0] tapPair;
  codeGroup_t  tapGroup;

  ////////////////////////////////////////////////////////////////////////////
  // Shift buffer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge aresetn)
  begin
    if (!aresetn)
    begin
      for (int w = 0; w < `WA_BUFFER_WORDS; w++)
        wordBuf[w] <= '0;
    end
    else
    begin
      wordBuf[0] <= dataIn;
      for (int w = 1; w < `WA_BUFFER_WORDS; w++)
        wordBuf[w] <= wordBuf[w-1];
    end
  end

  // Newest word in the low half
  assign window  = {wordBuf[1], wordBuf[0]};
  // Same pair two cycles later
  assign tapPair = {wordBuf[3], wordBuf[2]};

  ////////////////////////////////////////////////////////////////////////////
  // Output selector
  ////////////////////////////////////////////////////////////////////////////

  // Ten-way mux, offset k takes pair bits k+9 down to k
  always_comb
  begin
    tapGroup = '0;
    for (int k = 0; k < 10; k++)
      if (offset == wordOffset_t'(k))
        tapGroup = tapPair[k +: 10];
  end

  // Zero until an offset has been chosen
  always_ff @(posedge CLK or negedge aresetn)
  begin
    if (!aresetn)
      alignedData <= '0;
    else if (!offsetValid)
      alignedData <= '0;
    else
      alignedData <= tapGroup;
  end

endmodule

`default_nettype wire

// ==== verilog/commaScanner.sv ====
// Per-offset comma run counters; once any offset is found all comparators stay blocked until scanEnable drops
`timescale 1ns/10ps
`default_nettype none

`include "wordAligner_settings.svh"

module commaScanner
  import lineCodePkg::*, alignerPkg::*;
(
  input  wire         CLK,
  input  wire         aresetn,
  input  logic [19:0] window,
  input  logic        scanEnable,
  output offsetMask_t offsetHot
);

  ////////////////////////////////////////////////////////////////////////////
  // Comma selection
  ////////////////////////////////////////////////////////////////////////////

  // Anything other than 1 or 7 falls back to K28.5
  localparam codeGroup_t commaPos =
    (`WA_COMMA_SELECT == 1) ? k28Dot1Pos :
    (`WA_COMMA_SELECT == 7) ? k28Dot7Pos :
                              k28Dot5Pos;
  localparam codeGroup_t commaNeg =
    (`WA_COMMA_SELECT == 1) ? k28Dot1Neg :
    (`WA_COMMA_SELECT == 7) ? k28Dot7Neg :
                              k28Dot5Neg;

  localparam runCount_t runTarget = runCount_t'(`WA_COMMAS_TO_DETECT);

  // Freezes detection once an offset is found
  logic anyHot;

  assign anyHot = |offsetHot;

  ////////////////////////////////////////////////////////////////////////////
  // Ten comparators and run counters
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < 10; k++)
  begin : gOffset
    codeGroup_t slice;
    logic       match;
    runCount_t  runCount;
    logic       hot;

    // Group at offset k
    assign slice = window[k+9:k];
    // Either disparity counts
    assign match = !anyHot && ((slice == commaPos) || (slice == commaNeg));

    always_ff @(posedge CLK or negedge aresetn)
    begin
      if (!aresetn)
      begin
        runCount <= '0;
        hot      <= 1'b0;
      end
      else if (!scanEnable)
      begin
        runCount <= '0;
        hot      <= 1'b0;
      end
      else if (runCount >= runTarget)
      begin
        // Run complete, hold count and flag it
        hot <= 1'b1;
      end
      else if (match)
        runCount <= runCount + runCount_t'(1);
      else
        runCount <= '0;
    end

    assign offsetHot[k] = hot;
  end

endmodule

`default_nettype wire

// ==== verilog/alignController.sv ====
// Offset selection FSM; several offsets found at once restart the search and aligned waits for the monitor
`timescale 1ns/10ps
`default_nettype none

module alignController
  import alignerPkg::*;
(
  input  wire         CLK,
  input  wire         aresetn,
  input  offsetMask_t offsetHot,
  input  logic        searching,
  output logic        scanEnable,
  output wordOffset_t offset,
  output logic        offsetValid,
  output logic        aligned
);

  alignState_t alignState;

  // Flag decode
  wordOffset_t hotOffset;
  logic [3:0]  hotCount;

  ////////////////////////////////////////////////////////////////////////////
  // Flag decode
  ////////////////////////////////////////////////////////////////////////////

  // Index of the highest set flag and the number of set flags
  always_comb
  begin
    hotOffset = '0;
    hotCount  = '0;
    for (int k = 0; k < 10; k++)
      if (offsetHot[k])
      begin
        hotOffset = wordOffset_t'(k);
        hotCount  = hotCount + 4'd1;
      end
  end

  // Scanner runs only while a search is open
  assign scanEnable = ((alignState == Select) || (alignState == Lock)) && !aligned;

  ////////////////////////////////////////////////////////////////////////////
  // Selection FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge aresetn)
  begin
    if (!aresetn)
    begin
      alignState  <= Idle;
      offset      <= '0;
      offsetValid <= 1'b0;
      aligned     <= 1'b0;
    end
    else
    begin
      case (alignState)
        Idle:
          if (searching)
          begin
            alignState  <= Select;
            offsetValid <= 1'b0;
            aligned     <= 1'b0;
          end
        Select:
          if (hotCount == 4'd1)
          begin
            offset      <= hotOffset;
            offsetValid <= 1'b1;
            alignState  <= Lock;
          end
          else if (hotCount != 4'd0)
            alignState <= Idle;   // ambiguous, search again
        Lock:
          if (!searching)
          begin
            // Monitor has confirmed the comma run
            aligned    <= 1'b1;
            alignState <= Settle;
          end
        default:
          alignState <= Idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/syncMonitor.sv ====
// Search/sync FSM; codeError is active high and searching restarts after WA_ERROR_TRIGGER errors in a row
`timescale 1ns/10ps
`default_nettype none

`include "wordAligner_settings.svh"

module syncMonitor
  import alignerPkg::*;
(
  input  wire         CLK,
  input  wire         aresetn,
  input  offsetMask_t offsetHot,
  input  logic        codeError,
  output logic        searching
);

  localparam errorCount_t errorTrigger = errorCount_t'(`WA_ERROR_TRIGGER);

  // Comma-found path
  logic [`WA_COMMA_DELAY-1:0] commaDelay;
  logic                       found;

  syncState_t  syncState;
  errorCount_t errorCount;

  ////////////////////////////////////////////////////////////////////////////
  // Comma-found delay line
  ////////////////////////////////////////////////////////////////////////////

  // Gives the controller time to latch the offset first
  always_ff @(posedge CLK or negedge aresetn)
  begin
    if (!aresetn)
    begin
      commaDelay <= '0;
      found      <= 1'b0;
    end
    else
    begin
      commaDelay <= {commaDelay[`WA_COMMA_DELAY-2:0], |offsetHot};
      found      <= commaDelay[`WA_COMMA_DELAY-1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Search/sync FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge aresetn)
  begin
    if (!aresetn)
    begin
      syncState <= Search;
      searching <= 1'b1;
    end
    else
    begin
      case (syncState)
        Search:
          if (found)
          begin
            syncState <= Sync;
            searching <= 1'b0;
          end
        Sync:
          // Too many bad groups in a row
          if (errorCount >= errorTrigger)
          begin
            syncState <= Search;
            searching <= 1'b1;
          end
        default:
        begin
          syncState <= Search;
          searching <= 1'b1;
        end
      endcase
    end
  end

  // Consecutive errors only, one good group clears it
  always_ff @(posedge CLK or negedge aresetn)
  begin
    if (!aresetn)
      errorCount <= '0;
    else if ((syncState == Sync) && codeError)
      errorCount <= errorCount + errorCount_t'(1);
    else
      errorCount <= '0;
  end

endmodule

`default_nettype wire

// ==== verilog/wordAligner.sv ====
// 8b/10b word aligner top; dataIn arrives every clock with bit 9 first and there is no back-pressure
`timescale 1ns/10ps
`default_nettype none

module wordAligner
  import lineCodePkg::*, alignerPkg::*;
(
  input  wire        CLK,
  input  wire        aresetn,
  input  codeGroup_t dataIn,
  input  logic       codeError,
  output codeGroup_t alignedData,
  output logic       aligned
);

  // Newest two words for the comparators
  logic [19:0] window;
  // One flag per found offset
  offsetMask_t offsetHot;
  logic        scanEnable;
  // Chosen offset and its qualifier
  wordOffset_t offset;
  logic        offsetValid;
  // High while no lock is held
  logic        searching;

  // Buffer and output tap
  codeGroupBuffer codeGroupBuffer_i (
    .CLK         (CLK),
    .aresetn     (aresetn),
    .dataIn      (dataIn),
    .offset      (offset),
    .offsetValid (offsetValid),
    .window      (window),
    .alignedData (alignedData)
  );

  // Comma run detection at all ten offsets
  commaScanner commaScanner_i (
    .CLK        (CLK),
    .aresetn    (aresetn),
    .window     (window),
    .scanEnable (scanEnable),
    .offsetHot  (offsetHot)
  );

  // Offset choice and aligned flag
  alignController alignController_i (
    .CLK         (CLK),
    .aresetn     (aresetn),
    .offsetHot   (offsetHot),
    .searching   (searching),
    .scanEnable  (scanEnable),
    .offset      (offset),
    .offsetValid (offsetValid),
    .aligned     (aligned)
  );

  // Sync confirmation and loss detection
  syncMonitor syncMonitor_i (
    .CLK       (CLK),
    .aresetn   (aresetn),
    .offsetHot (offsetHot),
    .codeError (codeError),
    .searching (searching)
  );

endmodule

`default_nettype wire

// ==== verification/wordAligner_checker.sv ====
// Bound into wordAligner and reads the controller state through the instance alignController_i
`timescale 1ns/10ps
`default_nettype none

module wordAlignerChecker
  import lineCodePkg::*, alignerPkg::*;
(
  input wire         CLK,
  input wire         aresetn,
  input codeGroup_t  alignedData,
  input logic        aligned,
  input logic        offsetValid,
  input logic        searching,
  input offsetMask_t offsetHot,
  input alignState_t alignState
);

  ////////////////////////////////////////////////////////////////////////////
  // Output qualification
  ////////////////////////////////////////////////////////////////////////////

  // Output register follows offsetValid one edge later
  zeroWithoutOffset: assert property (
    @(posedge CLK) disable iff (!aresetn)
    !offsetValid |=> (alignedData == '0)
  ) else $error("alignedData is not zero without a valid offset");

  // Lock only after the monitor has left Search
  alignedAfterSync: assert property (
    @(posedge CLK) disable iff (!aresetn)
    $rose(aligned) |-> !$past(searching)
  ) else $error("aligned rose while searching was high");

  // Lock always points at a stored offset
  alignedHasOffset: assert property (
    @(posedge CLK) disable iff (!aresetn)
    aligned |-> offsetValid
  ) else $error("aligned is high without a valid offset");

  ////////////////////////////////////////////////////////////////////////////
  // Scanner flags
  ////////////////////////////////////////////////////////////////////////////

  // Scanner is off in Idle so its flags clear on the next edge
  flagsClearInIdle: assert property (
    @(posedge CLK) disable iff (!aresetn)
    (alignState == Idle) |=> (offsetHot == '0)
  ) else $error("offsetHot is still set one cycle after Idle");

endmodule

bind wordAligner wordAlignerChecker wordAlignerChecker_i (
  .CLK         (CLK),
  .aresetn     (aresetn),
  .alignedData (alignedData),
  .aligned     (aligned),
  .offsetValid (offsetValid),
  .searching   (searching),
  .offsetHot   (offsetHot),
  .alignState  (alignController_i.alignState)
);

`default_nettype wire

// ==== verification/wordAlignerTb.sv ====
// Directed tests for wordAligner with a stream that never stalls and a fixed 3-cycle output lag
`timescale 1ns/10ps
`default_nettype none

`include "wordAligner_settings.svh"

module wordAlignerTb
  import lineCodePkg::*;
();

  localparam int halfPeriod  = 20;
  localparam int resetCycles = 16;
  localparam int lockLimit   = 40;
  localparam int lossLimit   = 4;
  localparam int idleGroups  = 60;
  localparam int shortGroups = 100;
  localparam int dataGroups  = 200;
  localparam int commaRun    = 16;
  // Resets, idle streams and four locked streams plus margin
  localparam int testCycles    = 4 * (resetCycles + 1) + idleGroups + shortGroups
                                 + 4 * (commaRun + dataGroups + lockLimit);
  localparam int timeoutCycles = 3 * testCycles;
  // Alternating idle group that is never a comma at any offset
  localparam codeGroup_t fillerGroup = 10'b0101010101;

  logic       CLK;
  logic       aresetn;
  codeGroup_t dataIn;
  logic       codeError;
  codeGroup_t alignedData;
  logic       aligned;

  // Current stream and its expected group list
  codeGroup_t txGroups[$];
  codeGroup_t txWords[$];
  int         slip;
  int         wordIdx;
  bit         checkData;
  // Minus one means aligned is not checked
  int         expectAligned;
  int         errors;
  int         dataChecks;
  int         commaChecks;
  int         cycles;
  integer     seed;

  always #halfPeriod CLK = ~CLK;

  wordAligner wordAligner_i (
    .CLK         (CLK),
    .aresetn     (aresetn),
    .dataIn      (dataIn),
    .codeError   (codeError),
    .alignedData (alignedData),
    .aligned     (aligned)
  );

  // Run limit
  always @(posedge CLK)
  begin
    cycles = cycles + 1;
    if (cycles > timeoutCycles)
    begin
      $display("Run stopped after %0d cycles because a test never finished", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting and code groups
  ////////////////////////////////////////////////////////////////////////////

  task automatic reportValue(input string name, input logic [9:0] expected,
                             input logic [9:0] actual);
    errors++;
    $display("ERROR at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
  endtask

  task automatic reportFailure(input string what);
    errors++;
    $display("At %0d ns %s", $time, what);
  endtask

  function automatic bit isComma(input codeGroup_t g);
    return (g == k28Dot1Pos) || (g == k28Dot1Neg) || (g == k28Dot5Pos) ||
           (g == k28Dot5Neg) || (g == k28Dot7Pos) || (g == k28Dot7Neg);
  endfunction

  // Comma chosen by WA_COMMA_SELECT with K28.5 as the fallback
  function automatic codeGroup_t selectedComma(input bit negative);
    case (`WA_COMMA_SELECT)
      1:       return negative ? k28Dot1Neg : k28Dot1Pos;
      7:       return negative ? k28Dot7Neg : k28Dot7Pos;
      default: return negative ? k28Dot5Neg : k28Dot5Pos;
    endcase
  endfunction

  // Data groups never equal a comma
  function automatic codeGroup_t randomGroup();
    logic [31:0] r;
    codeGroup_t  g;
    r = $random(seed);
    g = r[9:0];
    while (isComma(g))
    begin
      r = $random(seed);
      g = r[9:0];
    end
    return g;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bit-stream model
  ////////////////////////////////////////////////////////////////////////////

  // Groups, then slip bits in front, then 10-bit words with bit 9 first
  task automatic buildStream(input int newSlip, input int commas, input int data,
                             input bit randomData);
    logic       bits[$];
    codeGroup_t w;
    int         nWords;
    txGroups.delete();
    txWords.delete();
    for (int i = 0; i < commas; i++)
      txGroups.push_back(selectedComma(i % 2 == 0));
    for (int i = 0; i < data; i++)
      txGroups.push_back(randomData ? randomGroup() : fillerGroup);
    // Slip bits carry on the idle pattern
    for (int b = 0; b < newSlip; b++)
      bits.push_back(b % 2 == 1);
    foreach (txGroups[g])
      for (int b = 9; b >= 0; b--)
        bits.push_back(txGroups[g][b]);
    while (bits.size() % 10 != 0)
      bits.push_back(bits.size() % 2 == 1);
    nWords = bits.size() / 10;
    for (int n = 0; n < nWords; n++)
    begin
      for (int b = 0; b < 10; b++)
        w[9 - b] = bits[10 * n + b];
      txWords.push_back(w);
    end
    slip    = newSlip;
    wordIdx = 0;
  endtask

  // One clock that samples at the falling edge before driving the next word
  task automatic stepCycle(input logic err);
    int m;
    @(negedge CLK);
    if ((expectAligned >= 0) && (aligned !== expectAligned[0]))
      reportValue("aligned", 10'(expectAligned), 10'(aligned));
    if (checkData)
    begin
      // Group completed three words before the newest captured one
      // A slipped group also needs the following word
      m = wordIdx - 4 - ((slip > 0) ? 1 : 0);
      if ((m >= 0) && (m < txGroups.size()))
      begin
        if (alignedData !== txGroups[m])
          reportValue("alignedData", txGroups[m], alignedData);
        dataChecks++;
        if (isComma(txGroups[m]))
          commaChecks++;
      end
    end
    dataIn    = (wordIdx < txWords.size()) ? txWords[wordIdx] : fillerGroup;
    codeError = err;
    wordIdx++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Shared sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic applyReset();
    @(negedge CLK);
    aresetn   = 1'b0;
    dataIn    = fillerGroup;
    codeError = 1'b0;
    checkData = 1'b0;
    for (int i = 0; i < resetCycles; i++)
    begin
      @(negedge CLK);
      if (aligned !== 1'b0)
        reportValue("aligned", 10'd0, 10'(aligned));
      if (alignedData !== 10'd0)
        reportValue("alignedData", 10'd0, alignedData);
    end
    aresetn = 1'b1;
  endtask

  // Output stays zero while no lock is expected
  task automatic idleCycles(input int n);
    expectAligned = 0;
    for (int i = 0; i < n; i++)
    begin
      stepCycle(1'b0);
      if (alignedData !== 10'd0)
        reportValue("alignedData", 10'd0, alignedData);
    end
  endtask

  task automatic waitForLock(input int limit);
    int n;
    n = 0;
    expectAligned = -1;
    while ((aligned !== 1'b1) && (n < limit))
    begin
      stepCycle(1'b0);
      n++;
    end
    if (aligned !== 1'b1)
      reportFailure("aligned did not rise after the comma run");
    checkData     = 1'b1;
    expectAligned = 1;
  endtask

  // Drive the rest of the stream until its last group has been compared
  task automatic finishStream();
    while (wordIdx < txWords.size() + 5)
      stepCycle(1'b0);
    if (commaChecks == 0)
      reportFailure("no comma of the run reached alignedData after lock");
    if (dataChecks < dataGroups)
      reportFailure("too few groups were compared after lock");
    checkData = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic resetTest();
    applyReset();
    buildStream(0, 0, idleGroups, 1'b0);
    idleCycles(idleGroups);
  endtask

  // One comma short of the run length
  task automatic shortRunTest();
    buildStream(3, `WA_COMMAS_TO_DETECT - 1, shortGroups, 1'b0);
    idleCycles(shortGroups);
  endtask

  task automatic alignTest(input int newSlip, input bit flush);
    applyReset();
    buildStream(newSlip, commaRun, dataGroups, 1'b1);
    dataChecks  = 0;
    commaChecks = 0;
    waitForLock(lockLimit);
    if (flush)
      finishStream();
  endtask

  // Lock and data survive one error fewer than the trigger
  task automatic errorToleranceTest();
    for (int i = 0; i < `WA_ERROR_TRIGGER - 1; i++)
      stepCycle(1'b1);
    for (int i = 0; i < 30; i++)
      stepCycle(1'b0);
  endtask

  task automatic lossTest(input int newSlip);
    int n;
    checkData     = 1'b0;
    expectAligned = -1;
    for (int i = 0; i < `WA_ERROR_TRIGGER; i++)
      stepCycle(1'b1);
    n = 0;
    while ((aligned !== 1'b0) && (n < lossLimit))
    begin
      stepCycle(1'b0);
      n++;
    end
    if (aligned !== 1'b0)
      reportFailure("aligned did not fall after the code error burst");
    // Fresh comma run at another slip
    buildStream(newSlip, commaRun, dataGroups, 1'b1);
    dataChecks  = 0;
    commaChecks = 0;
    waitForLock(lockLimit);
    finishStream();
  endtask

  initial
  begin
    CLK           = 1'b0;
    aresetn       = 1'b0;
    dataIn        = fillerGroup;
    codeError     = 1'b0;
    seed          = 32'ha8fe_1966;
    errors        = 0;
    cycles        = 0;
    slip          = 0;
    wordIdx       = 0;
    checkData     = 1'b0;
    expectAligned = -1;
    dataChecks    = 0;
    commaChecks   = 0;

    resetTest();
    shortRunTest();
    alignTest(0, 1'b1);
    alignTest(4, 1'b1);
    // Last lock stays up for the error tests
    alignTest(9, 1'b0);
    errorToleranceTest();
    lossTest(6);

    $display("Finished with %0d errors after %0d cycles", errors, cycles);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/lineCodePkg.sv
verilog/alignerPkg.sv
verilog/codeGroupBuffer.sv
verilog/commaScanner.sv
verilog/alignController.sv
verilog/syncMonitor.sv
verilog/wordAligner.sv
verification/wordAligner_checker.sv
verification/wordAlignerTb.sv

// ==== Makefile ====
# Verilator flow for the word aligner testbench

TOP = wordAlignerTb

.PHONY: all lint clean

# Build, run, then look for the pass line in the simulator output
all:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps \
		-f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
